// ==== include/rv32i_params.svh ====
`ifndef RV32I_PARAMS_SVH
`define RV32I_PARAMS_SVH

// datapath width
`define RV_XLEN 32

// x0..x31
`define RV_REG_AW 5

// addi x0, x0, 0
`define RV_NOP_INST 32'h0000_0013

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0060

`endif

// ==== design/rv32i_types.sv ====
`include "rv32i_params.svh"

package rv32i_types;

    typedef logic [`RV_XLEN-1:0] rv32i_word;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // same values as branch funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {
        mux1_rs1 = 1'b0,
        mux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        mux2_i_imm = 3'd0,
        mux2_u_imm = 3'd1,
        mux2_b_imm = 3'd2,
        mux2_s_imm = 3'd3,
        mux2_j_imm = 3'd4,
        mux2_rs2   = 3'd5
    } alumux2_sel_t;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_wb   = 2'd1,
        fwd_mem  = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        rv32i_opcode_t opcode;
        alu_op_t       aluop;
        cmp_op_t       cmpop;
        alumux1_sel_t  alumux1_sel;
        alumux2_sel_t  alumux2_sel;
        logic          load_regfile;
        logic          mem_read;
        logic          mem_write;
        logic [2:0]    funct3;
    } ex_ctrl_t;

    typedef struct packed {
        rv32i_word              alu_out;
        rv32i_word              rs2_data; // store data
        logic [`RV_REG_AW-1:0]  rd;
        ex_ctrl_t               ctrl;
        logic                   trap;
    } ex_mem_t;

endpackage

// ==== design/alu.sv ====
module alu (
    input  rv32i_types::alu_op_t   aluop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output rv32i_types::rv32i_word f
);
    import rv32i_types::*;

    logic [4:0] shamt;

    assign shamt = b[4:0]; // only low five bits shift

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'b0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = rv32i_word'($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b; // unused codes behave as add
        endcase
    end

endmodule

// ==== design/cmp.sv ====
module cmp (
    input  rv32i_types::cmp_op_t   cmpop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output logic                   br_en
);
    import rv32i_types::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (cmpop)
            beq:     br_en = eq;
            bne:     br_en = !eq;
            blt:     br_en = lt_s;
            bge:     br_en = !lt_s;
            bltu:    br_en = lt_u;
            bgeu:    br_en = !lt_u;
            default: br_en = 1'b0; // funct3 010/011 never compare
        endcase
    end

endmodule

// ==== design/execute_stage.sv ====
`include "rv32i_params.svh"

module execute_stage (
    input  rv32i_types::rv32i_word inst,
    input  rv32i_types::rv32i_word rs1_data,
    input  rv32i_types::rv32i_word rs2_data,
    input  rv32i_types::rv32i_word pc,
    input  rv32i_types::rv32i_word wb_data,
    input  rv32i_types::rv32i_word mem_fwd_data,
    input  logic [`RV_REG_AW-1:0]  rd,
    input  rv32i_types::ex_ctrl_t  ctrl,
    input  rv32i_types::fwd_sel_t  forward1,
    input  rv32i_types::fwd_sel_t  forward2,
    output rv32i_types::ex_mem_t   ex_result,
    output logic                   true_branch,
    output rv32i_types::rv32i_word branch_pc
);
    import rv32i_types::*;

    rv32i_word     i_imm, s_imm, b_imm, u_imm, j_imm;
    rv32i_word     fwd1_out, fwd2_out;
    rv32i_word     alu_a, alu_b, alu_out;
    logic          br_en;
    logic          trap;
    rv32i_opcode_t opcode;
    logic [2:0]    funct3;

    function automatic rv32i_word fwd_mux(
        input fwd_sel_t  sel,
        input rv32i_word reg_val,
        input rv32i_word wb_val,
        input rv32i_word mem_val
    );
        case (sel)
            fwd_wb:  fwd_mux = wb_val;
            fwd_mem: fwd_mux = mem_val;
            default: fwd_mux = reg_val;
        endcase
    endfunction

    assign fwd1_out = fwd_mux(forward1, rs1_data, wb_data, mem_fwd_data);
    assign fwd2_out = fwd_mux(forward2, rs2_data, wb_data, mem_fwd_data);

    // immediates, sign bit is always inst[31]
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (ctrl.alumux1_sel)
            mux1_pc: alu_a = pc; // auipc, jal link
            default: alu_a = fwd1_out;
        endcase

        case (ctrl.alumux2_sel)
            mux2_i_imm: alu_b = i_imm;
            mux2_u_imm: alu_b = u_imm;
            mux2_b_imm: alu_b = b_imm;
            mux2_s_imm: alu_b = s_imm;
            mux2_j_imm: alu_b = j_imm;
            default:    alu_b = fwd2_out;
        endcase
    end

    alu alu_i (
        .aluop (ctrl.aluop),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_out)
    );

    cmp cmp_i (
        .cmpop (ctrl.cmpop),
        .a     (fwd1_out),
        .b     (fwd2_out),
        .br_en (br_en)
    );

    // redirect for fetch
    always_comb begin
        case (ctrl.opcode)
            op_jal: begin
                true_branch = 1'b1;
                branch_pc   = pc + j_imm;
            end
            op_jalr: begin
                true_branch = 1'b1;
                branch_pc   = (fwd1_out + i_imm) & ~rv32i_word'(1);
            end
            op_br: begin
                true_branch = br_en;
                branch_pc   = pc + b_imm;
            end
            default: begin
                true_branch = 1'b0;
                branch_pc   = '0;
            end
        endcase
    end

    assign opcode = rv32i_opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];

    always_comb begin
        trap = 1'b0;
        case (opcode)
            op_lui, op_auipc, op_jal, op_jalr, op_imm, op_reg: trap = 1'b0;
            op_br: begin
                case (cmp_op_t'(funct3))
                    beq, bne, blt, bge, bltu, bgeu: trap = 1'b0;
                    default: trap = 1'b1;
                endcase
            end
            op_load: begin
                case (funct3)
                    3'b000, 3'b001, 3'b010: trap = 1'b0; // lb lh lw
                    3'b100, 3'b101:         trap = 1'b0; // lbu lhu
                    default:                trap = 1'b1;
                endcase
            end
            op_store: trap = (funct3 > 3'b010); // only sb sh sw
            default:  trap = 1'b1;
        endcase
    end

    assign ex_result = '{
        alu_out:  alu_out,
        rs2_data: fwd2_out,
        rd:       rd,
        ctrl:     ctrl,
        trap:     trap
    };

    // hazard unit never asks for a fourth source
    always_comb begin
        assert (forward1 !== 2'b11 && forward2 !== 2'b11)
            else $error("illegal forward select %0d/%0d", forward1, forward2);
    end

endmodule

// ==== design/ex_mem_reg.sv ====
module ex_mem_reg (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 stall,
    input  logic                 bubble,
    input  rv32i_types::ex_mem_t d,
    output rv32i_types::ex_mem_t q
);
    import rv32i_types::*;

    ex_mem_t d_bubble;

    // keep payload, kill everything with a side effect
    assign d_bubble = '{
        alu_out:  d.alu_out,
        rs2_data: d.rs2_data,
        rd:       '0,
        ctrl:     '0,
        trap:     1'b0
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (!stall) begin
            if (bubble) begin
                q <= d_bubble;
            end else begin
                q <= d;
            end
        end
    end

    // back-pressure from MEM freezes the whole entry
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> $stable(q)
    ) else $error("ex_mem changed during stall");

    // a bubble must never write the register file downstream
    a_bubble_no_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        (bubble && !stall) |=> !q.ctrl.load_regfile
    ) else $error("bubble left load_regfile set");

endmodule

// ==== design/execute_unit.sv ====
`include "rv32i_params.svh"

module execute_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv32i_types::rv32i_word inst,
    input  rv32i_types::rv32i_word rs1_data,
    input  rv32i_types::rv32i_word rs2_data,
    input  rv32i_types::rv32i_word pc,
    input  logic [`RV_REG_AW-1:0]  rd,
    input  rv32i_types::ex_ctrl_t  ctrl,
    input  rv32i_types::fwd_sel_t  forward1,
    input  rv32i_types::fwd_sel_t  forward2,
    input  rv32i_types::rv32i_word wb_data,
    input  logic                   stall,
    input  logic                   bubble,
    output rv32i_types::ex_mem_t   ex_mem,
    output logic                   true_branch,
    output rv32i_types::rv32i_word branch_pc
);
    import rv32i_types::*;

    ex_mem_t ex_result;

    execute_stage execute_stage_i (
        .inst         (inst),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .wb_data      (wb_data),
        .mem_fwd_data (ex_mem.alu_out), // previous result from MEM
        .rd           (rd),
        .ctrl         (ctrl),
        .forward1     (forward1),
        .forward2     (forward2),
        .ex_result    (ex_result),
        .true_branch  (true_branch),
        .branch_pc    (branch_pc)
    );

    ex_mem_reg ex_mem_reg_i (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall),
        .bubble (bubble),
        .d      (ex_result),
        .q      (ex_mem)
    );

endmodule

// ==== tests/tb_execute_unit.sv ====
`include "rv32i_params.svh"

module tb_execute_unit;
    import rv32i_types::*;

    localparam int nfields = 16;
    localparam int max_vec = 64;

    // column positions in stim_ex.txt
    localparam int c_id     = 0;
    localparam int c_inst   = 1;
    localparam int c_rs1    = 2;
    localparam int c_rs2    = 3;
    localparam int c_pc     = 4;
    localparam int c_rd     = 5;
    localparam int c_ctrl   = 6;
    localparam int c_fwd    = 7;
    localparam int c_wb     = 8;
    localparam int c_stall  = 9;
    localparam int c_bubble = 10;
    localparam int c_alu    = 11;
    localparam int c_store  = 12;
    localparam int c_trap   = 13;
    localparam int c_taken  = 14;
    localparam int c_target = 15;

    logic                  clk;
    logic                  arst_n;
    rv32i_word             inst, rs1_data, rs2_data, pc, wb_data;
    logic [`RV_REG_AW-1:0] rd;
    ex_ctrl_t              ctrl;
    fwd_sel_t              forward1, forward2;
    logic                  stall, bubble;
    ex_mem_t               ex_mem;
    logic                  true_branch;
    rv32i_word             branch_pc;

    logic [31:0]           stim [0:nfields*max_vec-1];
    int                    num_vec;
    int                    err_count, err_mark, pass_count, fail_count;
    int                    cur_id;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;
    logic [`RV_REG_AW-1:0] exp_rd;   // register model for rd
    ex_ctrl_t              exp_ctrl; // and for the control word

    execute_unit dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst        (inst),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .rd          (rd),
        .ctrl        (ctrl),
        .forward1    (forward1),
        .forward2    (forward2),
        .wb_data     (wb_data),
        .stall       (stall),
        .bubble      (bubble),
        .ex_mem      (ex_mem),
        .true_branch (true_branch),
        .branch_pc   (branch_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("simulation timed out after %0d cycles before all vectors ran", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t: vec %0d %s is %h, expected %h", $time, cur_id, what, got, exp);
            err_count++;
        end
    endtask

    task automatic apply_vector(input int v);
        int b;
        b        = v * nfields;
        cur_id   = stim[b + c_id];
        inst     = stim[b + c_inst];
        rs1_data = stim[b + c_rs1];
        rs2_data = stim[b + c_rs2];
        pc       = stim[b + c_pc];
        rd       = stim[b + c_rd][`RV_REG_AW-1:0];
        ctrl     = ex_ctrl_t'(stim[b + c_ctrl][23:0]);
        forward1 = fwd_sel_t'(stim[b + c_fwd][5:4]);
        forward2 = fwd_sel_t'(stim[b + c_fwd][1:0]);
        wb_data  = stim[b + c_wb];
        stall    = stim[b + c_stall][0];
        bubble   = stim[b + c_bubble][0];
        if (!stall && bubble) begin
            exp_rd   = '0;
            exp_ctrl = '0;
        end else if (!stall) begin
            exp_rd   = rd;
            exp_ctrl = ctrl;
        end
    endtask

    // same-cycle fetch redirect
    task automatic check_redirect(input int v);
        int b;
        b = v * nfields;
        compare({31'b0, true_branch}, stim[b + c_taken], "true_branch");
        compare(branch_pc, stim[b + c_target], "branch_pc");
    endtask

    task automatic verify_ex_mem(input int v);
        int b;
        b = v * nfields;
        compare(ex_mem.alu_out, stim[b + c_alu], "alu_out");
        compare(ex_mem.rs2_data, stim[b + c_store], "store data");
        compare({31'b0, ex_mem.trap}, stim[b + c_trap], "trap");
        compare({{(32-`RV_REG_AW){1'b0}}, ex_mem.rd}, {{(32-`RV_REG_AW){1'b0}}, exp_rd}, "rd");
        compare({8'b0, ex_mem.ctrl}, {8'b0, exp_ctrl}, "ctrl");
    endtask

    task automatic report_vector();
        if (err_count == err_mark) begin
            pass_count++;
            $display("vec %0d: pass", cur_id);
        end else begin
            fail_count++;
            $display("vec %0d: %0d mismatches", cur_id, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    initial begin
        for (int i = 0; i < nfields * max_vec; i++) begin
            stim[i] = '0;
        end
        $readmemh("tests/stim_ex.txt", stim);
        num_vec = 0;
        while (num_vec < max_vec && stim[num_vec * nfields + c_id] != 0) begin
            num_vec++;
        end
        cycle_limit = 4 * num_vec + 50;

        // live inputs during reset, so only the reset keeps ex_mem at zero
        arst_n     = 1'b0;
        inst       = `RV_NOP_INST;
        rs1_data   = '0;
        rs2_data   = 32'h0000_0bad;
        pc         = `RV_RESET_PC;
        rd         = 5'd1;
        ctrl       = '0;
        ctrl.opcode       = op_imm;
        ctrl.alumux1_sel  = mux1_pc; // alu_out would carry the pc
        ctrl.load_regfile = 1'b1;
        forward1   = fwd_none;
        forward2   = fwd_none;
        wb_data    = '0;
        stall      = 1'b0;
        bubble     = 1'b0;
        err_count  = 0;
        err_mark   = 0;
        pass_count = 0;
        fail_count = 0;
        cur_id     = 0;
        exp_rd     = '0;
        exp_ctrl   = '0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // vec 0 is the state left by reset
        compare(ex_mem.alu_out, '0, "alu_out after reset");
        compare(ex_mem.rs2_data, '0, "store data after reset");
        compare({2'b0, ex_mem.rd, ex_mem.ctrl, ex_mem.trap}, '0, "control after reset");
        report_vector();

        for (int v = 0; v < num_vec; v++) begin
            if (v > 0) begin
                @(negedge clk);
                verify_ex_mem(v - 1);
                report_vector();
            end
            apply_vector(v);
            #1;
            check_redirect(v);
        end
        if (num_vec > 0) begin
            @(negedge clk);
            verify_ex_mem(num_vec - 1);
            report_vector();
        end else begin
            $display("no vectors were read from tests/stim_ex.txt");
            fail_count++;
        end

        $display("passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
design/rv32i_types.sv
design/alu.sv
design/cmp.sv
design/execute_stage.sv
design/ex_mem_reg.sv
design/execute_unit.sv
tests/tb_execute_unit.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module tb_execute_unit -o sim_execute_unit

# the simulator may stop early on an assertion, so its status is not used
out=$(./obj_dir/sim_execute_unit 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// ==== tests/stim_ex.txt ====
// all hex: id inst rs1 rs2 pc rd ctrl fwd(f1,f2) wb stall bubble
//          then expected alu_out store_data trap (after clock), true_branch branch_pc (same cycle)
01 002081b3 00000005 00000007 000 03 660160 00 00000000 0 0 0000000c 00000007 0 0 0000
02 002081b3 00000005 00000007 000 03 662160 00 00000000 0 0 fffffffe 00000007 0 0 0000
03 002081b3 00000003 00000024 000 03 664161 00 00000000 0 0 00000030 00000024 0 0 0000
04 002081b3 ffffffff 00000001 000 03 666162 00 00000000 0 0 00000001 00000001 0 0 0000
05 002081b3 ffffffff 00000001 000 03 668163 00 00000000 0 0 00000000 00000001 0 0 0000
06 002081b3 f0f0f0f0 0ff00ff0 000 03 66a164 00 00000000 0 0 ff00ff00 0ff00ff0 0 0 0000
07 002081b3 80000000 00000004 000 03 66c165 00 00000000 0 0 08000000 00000004 0 0 0000
08 002081b3 80000000 00000004 000 03 66e165 00 00000000 0 0 f8000000 00000004 0 0 0000
09 002081b3 12340000 00005678 000 03 670166 00 00000000 0 0 12345678 00005678 0 0 0000
0a 002081b3 12345678 0000ffff 000 03 672167 00 00000000 0 0 00005678 0000ffff 0 0 0000
0b ff008293 00000100 deadbeef 000 05 260020 00 00000000 0 0 000000f0 deadbeef 0 0 0000
0c 12345337 00000000 00000000 000 06 6e0060 00 00000000 0 0 12345000 00000000 0 0 0000
0d 00001397 00000000 00000000 060 07 2e0260 00 00000000 0 0 00001060 00000000 0 0 0000
0e 0020a423 00001000 cafef00d 000 00 4600ca 00 00000000 0 0 00001008 cafef00d 0 0 0000
0f ffc0a203 00002000 00000000 000 04 060032 00 00000000 0 0 00001ffc 00000000 0 0 0000
10 002081b3 11111111 00000001 000 03 660160 10 00000100 0 0 00000101 00000001 0 0 0000
11 002081b3 22222222 33333333 000 03 660160 21 00000010 0 0 00000111 00000010 0 0 0000
12 0020a423 00000300 00000bad 000 00 4600ca 02 00000000 0 0 00000308 00000111 0 0 0000
13 002081b3 00000400 00000999 000 03 662160 02 00000000 0 0 000000f8 00000308 0 0 0000
14 00208863 00000055 00000055 100 00 c60280 00 00000000 0 0 00000110 00000055 0 1 0110
15 00208863 fffffff0 00000005 100 00 c60280 00 00000000 0 0 00000110 00000005 0 0 0110
16 00209863 00000055 00000055 100 00 c60681 00 00000000 0 0 00000110 00000055 0 0 0110
17 00209863 fffffff0 00000005 100 00 c60681 00 00000000 0 0 00000110 00000005 0 1 0110
18 0020c863 fffffff0 00000005 100 00 c61284 00 00000000 0 0 00000110 00000005 0 1 0110
19 0020c863 00000055 00000055 100 00 c61284 00 00000000 0 0 00000110 00000055 0 0 0110
1a 0020d863 00000055 00000055 100 00 c61685 00 00000000 0 0 00000110 00000055 0 1 0110
1b 0020d863 fffffff0 00000005 100 00 c61685 00 00000000 0 0 00000110 00000005 0 0 0110
1c 0020e863 00000005 fffffff0 100 00 c61a86 00 00000000 0 0 00000110 fffffff0 0 1 0110
1d 0020e863 00000055 00000055 100 00 c61a86 00 00000000 0 0 00000110 00000055 0 0 0110
1e 0020f863 fffffff0 00000005 100 00 c61e87 00 00000000 0 0 00000110 00000005 0 1 0110
1f 0020f863 00000005 fffffff0 100 00 c61e87 00 00000000 0 0 00000110 fffffff0 0 0 0110
20 020000ef 00000000 00000000 200 01 de0320 00 00000000 0 0 00000220 00000000 0 1 0220
21 005100e7 00001000 00000000 000 01 ce0020 00 00000000 0 0 00001005 00000000 0 1 1004
22 0000007f 00000077 00000000 000 00 000000 00 00000000 0 0 00000077 00000000 1 0 0000
23 0020a863 00000055 00000055 100 00 c60a82 00 00000000 0 0 00000110 00000055 1 0 0110
24 ffc0b203 00002000 00000000 000 04 060033 00 00000000 0 0 00001ffc 00000000 1 0 0000
25 0020c423 00001000 00001234 000 00 4600cc 00 00000000 0 0 00001008 00001234 1 0 0000
26 002081b3 00000001 00000002 000 03 660160 00 00000000 1 0 00001008 00001234 1 0 0000
27 ffc0b203 00002000 00000000 000 04 060033 00 00000000 0 1 00001ffc 00000000 0 0 0000
28 002081b3 00000001 00000002 000 03 660160 00 00000000 1 1 00001ffc 00000000 0 0 0000
29 002081b3 00000001 00000002 000 03 660160 00 00000000 0 0 00000003 00000002 0 0 0000
